// ==== include/audio_config.svh ====
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Sample widths
////////////////////////////////////////////////////////////////////////////

`define AUDIO_SAMPLE_W 16
`define AUDIO_ACC_W    18

////////////////////////////////////////////////////////////////////////////
// Master boost curves
////////////////////////////////////////////////////////////////////////////

// F is the slope divisor above the knee
// A is the gain below the knee
`define COMP_LO_F 4
`define COMP_LO_A 2
`define COMP_HI_F 8
`define COMP_HI_A 4

`endif

// ==== src/audio_pkg.sv ====
`include "audio_config.svh"

package audio_pkg;

	// One signed sample from any sound source
	typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

	// Mixing accumulator
	// Two extra bits of headroom for the CD boost sum
	typedef logic signed [`AUDIO_ACC_W-1:0] acc_t;

	// Master boost setting
	// The unused code 2'b11 is treated as the 4x curve
	typedef enum logic [1:0] {
		BOOST_OFF = 2'd0,
		BOOST_2X  = 2'd1,
		BOOST_4X  = 2'd2
	} boost_mode_t;

endpackage

// ==== src/voice_bus_if.sv ====
`timescale 1ns/10ps

interface voice_bus_if
	import audio_pkg::*;
();

	// Voices after attenuation
	sample_t cdda_l;
	sample_t cdda_r;
	sample_t adpcm;
	sample_t psg_l;
	sample_t psg_r;

	// One-cycle strobe, no back-pressure
	logic    valid;

	modport source (
		output cdda_l, cdda_r, adpcm, psg_l, psg_r, valid
	);

	modport sink (
		input cdda_l, cdda_r, adpcm, psg_l, psg_r, valid
	);

endinterface

// ==== src/voice_attenuator.sv ====
`timescale 1ns/10ps

module voice_attenuator
	import audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        sample_valid,
	input  sample_t     cdda_l,
	input  sample_t     cdda_r,
	input  sample_t     adpcm,
	input  sample_t     psg_l,
	input  sample_t     psg_r,
	voice_bus_if.source bus
);

	// Half plus quarter plus a last smaller term
	// Each shift floors on its own before the sum
	function automatic sample_t shift_sum(input sample_t s, input int unsigned last);
		shift_sum = (s >>> 1) + (s >>> 2) + (s >>> last);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Input capture
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (sample_valid) begin
			// CD audio goes through at full level
			bus.cdda_l <= cdda_l;
			bus.cdda_r <= cdda_r;
			// PSG at about 0.81, ADPCM at 0.875
			bus.psg_l  <= shift_sum(psg_l, 4);
			bus.psg_r  <= shift_sum(psg_r, 4);
			bus.adpcm  <= shift_sum(adpcm, 3);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bus.valid <= 1'b0;
		end else begin
			bus.valid <= sample_valid;
		end
	end

endmodule

// ==== src/channel_mixer.sv ====
`timescale 1ns/10ps

`include "audio_config.svh"

module channel_mixer
	import audio_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      cd_boost,
	voice_bus_if.sink bus,
	output sample_t   mix_l,
	output sample_t   mix_r,
	output logic      mix_valid
);

	acc_t sum_l;
	acc_t sum_r;
	logic sum_valid;
	acc_t scaled_l;
	acc_t scaled_r;

	// All voices of one channel in accumulator width
	function automatic acc_t voice_sum(input sample_t cdda, psg, voice, input logic boost);
		acc_t cd_term;
		cd_term = acc_t'(cdda);
		voice_sum = cd_term + (boost ? cd_term : acc_t'(0)) + acc_t'(psg) + acc_t'(voice);
	endfunction

	// Without CD boost the sum gets 5/4 to fill the range again
	function automatic acc_t headroom(input acc_t sum, input logic boost);
		headroom = boost ? sum : sum + (sum >>> 2);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stage 1, summing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (bus.valid) begin
			sum_l <= voice_sum(bus.cdda_l, bus.psg_l, bus.adpcm, cd_boost);
			sum_r <= voice_sum(bus.cdda_r, bus.psg_r, bus.adpcm, cd_boost);
		end
		if (sum_valid) begin
			scaled_l <= headroom(sum_l, cd_boost);
			scaled_r <= headroom(sum_r, cd_boost);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 2 strobe and output
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sum_valid <= 1'b0;
			mix_valid <= 1'b0;
		end else begin
			sum_valid <= bus.valid;
			mix_valid <= sum_valid;
		end
	end

	// Top sixteen accumulator bits
	assign mix_l = scaled_l[`AUDIO_ACC_W-1 -: `AUDIO_SAMPLE_W];
	assign mix_r = scaled_r[`AUDIO_ACC_W-1 -: `AUDIO_SAMPLE_W];

	a_mix_latency: assert property (@(posedge clk_sys) disable iff (reset)
		mix_valid == $past(bus.valid, 2))
	else $error("mix_valid is not two cycles behind the voice bus strobe");

endmodule

// ==== src/soft_compressor.sv ====
`timescale 1ns/10ps

`include "audio_config.svh"

module soft_compressor
	import audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  boost_mode_t master_boost,
	input  sample_t     in_sample,
	input  logic        in_valid,
	output sample_t     out_sample,
	output logic        out_valid
);

	localparam int W = `AUDIO_SAMPLE_W;

	// Knee sits one above the exact crossing so the top end cannot wrap
	localparam int LO_X = ((32767 * (`COMP_LO_F - 1)) / ((`COMP_LO_F * `COMP_LO_A) - 1)) + 1;
	localparam int LO_B = LO_X * `COMP_LO_A;
	localparam int HI_X = ((32767 * (`COMP_HI_F - 1)) / ((`COMP_HI_F * `COMP_HI_A) - 1)) + 1;
	localparam int HI_B = HI_X * `COMP_HI_A;

	logic [W-1:0] mag;
	logic [W-1:0] lo_val;
	logic [W-1:0] hi_val;
	logic [W-1:0] shaped;
	sample_t      comp_sample;

	// Two segments, steep gain below the knee and a flat tail above
	function automatic logic [W-1:0] curve(input logic [W-1:0] m, input int x, b, a, f);
		if (m < x) begin
			curve = W'(m * a);
		end else begin
			curve = W'(((m - x) / f) + b);
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Magnitude, curve, sign
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		mag    = in_sample[W-1] ? (~in_sample) + 1'b1 : in_sample;
		lo_val = curve(mag, LO_X, LO_B, `COMP_LO_A, `COMP_LO_F);
		hi_val = curve(mag, HI_X, HI_B, `COMP_HI_A, `COMP_HI_F);
		// Code 2'b11 lands on the 4x curve
		shaped = (master_boost == BOOST_2X) ? lo_val : hi_val;
		comp_sample = in_sample[W-1] ? sample_t'(-shaped) : sample_t'(shaped);
	end

	always_ff @(posedge clk_sys) begin
		if (in_valid) begin
			out_sample <= (master_boost == BOOST_OFF) ? in_sample : comp_sample;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	a_comp_latency: assert property (@(posedge clk_sys) disable iff (reset)
		out_valid == $past(in_valid))
	else $error("out_valid is not one cycle behind in_valid");

endmodule

// ==== src/audio_mix_top.sv ====
`timescale 1ns/10ps

module audio_mix_top
	import audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        sample_valid,
	input  sample_t     cdda_l,
	input  sample_t     cdda_r,
	input  sample_t     adpcm,
	input  sample_t     psg_l,
	input  sample_t     psg_r,
	input  logic        cd_boost,
	input  boost_mode_t master_boost,
	output sample_t     audio_l,
	output sample_t     audio_r,
	output logic        out_valid
);

	sample_t mix_l;
	sample_t mix_r;
	logic    mix_valid;

	voice_bus_if voice_bus ();

	voice_attenuator attenuator (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sample_valid (sample_valid),
		.cdda_l       (cdda_l),
		.cdda_r       (cdda_r),
		.adpcm        (adpcm),
		.psg_l        (psg_l),
		.psg_r        (psg_r),
		.bus          (voice_bus.source)
	);

	channel_mixer mixer (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cd_boost  (cd_boost),
		.bus       (voice_bus.sink),
		.mix_l     (mix_l),
		.mix_r     (mix_r),
		.mix_valid (mix_valid)
	);

	// Both channels share one strobe, the left one is brought out
	soft_compressor compressor_l (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.master_boost (master_boost),
		.in_sample    (mix_l),
		.in_valid     (mix_valid),
		.out_sample   (audio_l),
		.out_valid    (out_valid)
	);

	soft_compressor compressor_r (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.master_boost (master_boost),
		.in_sample    (mix_r),
		.in_valid     (mix_valid),
		.out_sample   (audio_r),
		.out_valid    ()
	);

endmodule

// ==== verification/audio_mix_tb.sv ====
`timescale 1ns/10ps

module audio_mix_tb
	import audio_pkg::*;
();

	localparam int MAX_CASES   = 64;
	localparam int IDLE_CYCLES = 10;
	localparam int LATENCY     = 4;

	logic        clk_sys;
	logic        reset;
	logic        sample_valid;
	sample_t     cdda_l;
	sample_t     cdda_r;
	sample_t     adpcm;
	sample_t     psg_l;
	sample_t     psg_r;
	logic        cd_boost;
	boost_mode_t master_boost;
	sample_t     audio_l;
	sample_t     audio_r;
	logic        out_valid;

	// Case table with inputs in file order cdda_l cdda_r adpcm psg_l psg_r
	string case_name [MAX_CASES];
	int    case_gap [MAX_CASES];
	int    case_cd [MAX_CASES];
	int    case_boost [MAX_CASES];
	int    case_in [MAX_CASES][5];
	int    case_exp_l [MAX_CASES];
	int    case_exp_r [MAX_CASES];

	int   n_cases       = 0;
	int   max_gap       = 0;
	int   load_errors   = 0;
	int   pass_count    = 0;
	int   fail_count    = 0;
	int   stray_count   = 0;
	int   budget_cycles = 0;
	int   cycle         = 0;
	logic checking      = 1'b0;

	// Samples in flight as case index and the cycle count where the output is due
	int exp_idx_q [$];
	int exp_due_q [$];

	audio_mix_top UUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sample_valid (sample_valid),
		.cdda_l       (cdda_l),
		.cdda_r       (cdda_r),
		.adpcm        (adpcm),
		.psg_l        (psg_l),
		.psg_r        (psg_r),
		.cd_boost     (cd_boost),
		.master_boost (master_boost),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.out_valid    (out_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Case file
	////////////////////////////////////////////////////////////////////////////

	task automatic load_cases();
		int    fd;
		int    r;
		bit    done;
		string tok;
		string rest;
		fd = $fopen("verification/audio_mix_cases.txt", "r");
		if (fd == 0) begin
			load_errors++;
			$display("could not open verification/audio_mix_cases.txt");
			return;
		end
		done = 1'b0;
		while (!done) begin
			r = $fscanf(fd, "%s", tok);
			if (r != 1 || n_cases >= MAX_CASES) begin
				done = 1'b1;
			end else if (tok[0] == "#") begin
				r = $fgets(rest, fd);
			end else begin
				r = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d", case_gap[n_cases],
					case_cd[n_cases], case_boost[n_cases], case_in[n_cases][0],
					case_in[n_cases][1], case_in[n_cases][2], case_in[n_cases][3],
					case_in[n_cases][4], case_exp_l[n_cases], case_exp_r[n_cases]);
				assert (r == 10) else begin
					load_errors++;
					$display("case %s holds only %0d of its 10 values", tok, r);
				end
				case_name[n_cases] = tok;
				if (case_gap[n_cases] > max_gap)
					max_gap = case_gap[n_cases];
				n_cases++;
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus driven right after a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic send_case(input int i);
		cdda_l       = sample_t'(case_in[i][0]);
		cdda_r       = sample_t'(case_in[i][1]);
		adpcm        = sample_t'(case_in[i][2]);
		psg_l        = sample_t'(case_in[i][3]);
		psg_r        = sample_t'(case_in[i][4]);
		sample_valid = 1'b1;
		// The next rising edge samples the strobe and the fourth one raises out_valid
		exp_idx_q.push_back(i);
		exp_due_q.push_back(cycle + LATENCY);
		@(negedge clk_sys);
		sample_valid = 1'b0;
	endtask

	// Boost inputs only change with nothing in flight
	task automatic drain_pipeline();
		while (exp_due_q.size() != 0)
			@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output checker
	////////////////////////////////////////////////////////////////////////////

	task automatic report_case(input int idx, input bit ok);
		if (ok) begin
			pass_count++;
			$display("case %s passed", case_name[idx]);
		end else begin
			fail_count++;
			$display("case %s failed", case_name[idx]);
		end
	endtask

	task automatic check_output();
		int idx;
		int due;
		bit ok;
		assert (!$isunknown(out_valid)) else begin
			stray_count++;
			$display("out_valid is unknown at cycle %0d", cycle);
		end
		if (out_valid === 1'b1) begin
			assert (exp_due_q.size() != 0) else begin
				stray_count++;
				$display("out_valid went high with no sample in flight at cycle %0d", cycle);
			end
			if (exp_due_q.size() != 0) begin
				idx = exp_idx_q.pop_front();
				due = exp_due_q.pop_front();
				ok  = 1'b1;
				assert (due == cycle) else begin
					ok = 1'b0;
					$display("case %s came out at cycle %0d, due at cycle %0d",
						case_name[idx], cycle, due);
				end
				assert (int'(audio_l) == case_exp_l[idx]) else begin
					ok = 1'b0;
					$display("mismatch %s audio_l expected %0d actual %0d",
						case_name[idx], case_exp_l[idx], int'(audio_l));
				end
				assert (int'(audio_r) == case_exp_r[idx]) else begin
					ok = 1'b0;
					$display("mismatch %s audio_r expected %0d actual %0d",
						case_name[idx], case_exp_r[idx], int'(audio_r));
				end
				report_case(idx, ok);
			end
		end else begin
			assert (exp_due_q.size() == 0 || exp_due_q[0] > cycle) else begin
				idx = exp_idx_q.pop_front();
				due = exp_due_q.pop_front();
				$display("case %s gave no output at cycle %0d", case_name[idx], due);
				report_case(idx, 1'b0);
			end
		end
	endtask

	always @(negedge clk_sys) begin
		if (checking)
			check_output();
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset        = 1'b1;
		sample_valid = 1'b0;
		cdda_l       = '0;
		cdda_r       = '0;
		adpcm        = '0;
		psg_l        = '0;
		psg_r        = '0;
		cd_boost     = 1'b0;
		master_boost = BOOST_OFF;
		load_cases();
		budget_cycles = n_cases * (max_gap + LATENCY + 2) + 20;

		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset    = 1'b0;
		checking = 1'b1;
		// Any out_valid in the idle stretch counts as a stray output
		repeat (IDLE_CYCLES) @(negedge clk_sys);

		for (int i = 0; i < n_cases; i++) begin
			if (case_cd[i] != int'(cd_boost) || case_boost[i] != int'(master_boost)) begin
				drain_pipeline();
				cd_boost     = case_cd[i][0];
				master_boost = boost_mode_t'(case_boost[i]);
			end
			repeat (case_gap[i]) @(negedge clk_sys);
			send_case(i);
		end
		while (exp_due_q.size() != 0)
			@(posedge clk_sys);
		repeat (LATENCY + 2) @(negedge clk_sys);

		$display("%0d cases passed, %0d cases failed, %0d stray outputs, %0d load errors",
			pass_count, fail_count, stray_count, load_errors);
		if (fail_count == 0 && stray_count == 0 && load_errors == 0 && pass_count == n_cases
			&& n_cases > 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Budget grows with the case count and the longest gap
	initial begin
		wait (budget_cycles > 0);
		repeat (budget_cycles) @(posedge clk_sys);
		$display("run timed out after %0d cycles before all cases were checked", budget_cycles);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== verification/audio_mix_cases.txt ====
# name gap cd_boost master_boost cdda_l cdda_r adpcm psg_l psg_r exp_l exp_r
# gap is idle cycles before the strobe; master_boost 0 off, 1 2x, 2 4x, 3 same as 4x
first_cd     0 0 0   1000  -1000      0      0      0    312   -313
psg_pos      2 0 0      0      0      0    100   1234     25    313
psg_neg      0 0 0      0      0      0   -100  -1234    -26   -314
adpcm_pos    1 0 0      0      0   1000      0      0    273    273
adpcm_neg    0 0 0      0      0  -1001      0      0   -275   -275
mix_all      0 0 0   8000  -6000   2000   3000  -4000   3808  -2344
max_pos_off  3 0 0  32767  32767  32767  32767  32767  27517  27517
max_neg_off  0 0 0 -32768 -32768 -32768 -32768 -32768 -27520 -27520
cdboost_unit 0 1 0   1000  -1000      0      0      0    500   -500
cdboost_mix  0 1 0   8000  -6000   2000   3000  -4000   5046  -3375
cdboost_odd  1 1 0     -3      7      0      0      0     -2      3
c2x_zero     0 1 1      0      0      0      0      0      0      0
c2x_below    0 1 1  28086 -28086      0      0      0  28086 -28086
c2x_knee     0 1 1  28088 -28088      0      0      0  28088 -28088
c2x_above    2 1 1  30000 -30001      0      0      0  28327 -28327
c2x_max_pos  0 1 1  32767  32767  32767  32767  32767  32128  32128
c2x_max_neg  0 1 1 -32768 -32768 -32768 -32768 -32768 -32129 -32129
c4x_zero     0 1 2      0      0      0      0      0      0      0
c4x_below    0 1 2  14798 -14798      0      0      0  29596 -29596
c4x_knee     0 1 2  14800 -14800      0      0      0  29600 -29600
c4x_small    1 1 2     -6   2001      0      0      0    -12   4000
c4x_max_pos  0 1 2  32767  32767  32767  32767  32767  32450  32450
c4x_max_neg  0 1 2 -32768 -32768 -32768 -32768 -32768 -32451 -32451
code3_as_4x  0 1 3  14800  20000      0      0      0  29600  29925
burst_1      3 0 0     16    -16      0      0      0      5     -5
burst_2      0 0 0    100   -100      0      0      0     31    -32
burst_3      0 0 0   4000  -4000      0      0      0   1250  -1250
burst_4      0 0 0      7     -7      0      0      0      2     -3
burst_5      0 0 0  32767 -32768      0      0      0  10239 -10240
burst_6      0 0 0     -1      1      0      0      0     -1      0
burst_7      0 0 0      0      0      0   1234  -1234    313   -314
burst_8      0 0 0      0      0   1000      0      0    273    273

// ==== tb.f ====
+incdir+include
src/audio_pkg.sv
src/voice_bus_if.sv
src/voice_attenuator.sv
src/channel_mixer.sv
src/soft_compressor.sv
src/audio_mix_top.sv
verification/audio_mix_tb.sv
